//--- design/freeCachePkg.sv
package freeCachePkg;

	// --------------------------------------------------
	// table geometry
	// --------------------------------------------------
	// entries 0..127 descriptor half, 128..255 object half
	localparam int TABLE_DEPTH = 256;
	localparam int ADDR_W = 8;

	// entry fields, selector sits above length in a table word
	localparam int SEL_W = 24;
	localparam int LEN_W = 32;

	// cachedMem and freeMem width
	localparam int MEM_W = 40;

	// --------------------------------------------------
	// command opcodes
	// --------------------------------------------------
	typedef enum logic [3:0] {
		opWrite,
		opClear,
		opFindFreeObject,
		opFindFreeEntry,
		opFindLength,
		opFindUsedEntry,
		opCalcCached,
		opMemClear,
		opMemAdd,
		opMemSub,
		opNone
	} cacheOpT;

	// scan sequencer states
	typedef enum logic [1:0] {stIdle, stWrite, stScan, stDrain} seqStateT;

endpackage

//--- design/freeObjectCache.sv
`timescale 1ns/1ps

module freeObjectCache #(
	parameter int TableDepth = freeCachePkg::TABLE_DEPTH,
	parameter int ReadLatency = 1
) (
	input logic CLK,
	input logic RESETn,
	input logic cmdStrobe,
	input freeCachePkg::cacheOpT cmdOp,
	input logic [freeCachePkg::SEL_W-1:0] selIn,
	input logic [freeCachePkg::LEN_W-1:0] lengthIn,
	output logic busy,
	output logic found,
	output logic [freeCachePkg::ADDR_W-1:0] foundAddr,
	output logic [freeCachePkg::SEL_W-1:0] foundSel,
	output logic [freeCachePkg::LEN_W-1:0] foundLength,
	output logic [freeCachePkg::MEM_W-1:0] cachedMem,
	output logic [freeCachePkg::MEM_W-1:0] freeMem
);

	// scan bus, table word is {selector, length}
	scanIf #(
		.TableDepth(TableDepth),
		.opT(freeCachePkg::cacheOpT),
		.entryT(logic [freeCachePkg::SEL_W+freeCachePkg::LEN_W-1:0])
	) bus ();

	// command decode and scan control
	scanSequencer seq_i (.CLK(CLK), .RESETn(RESETn), .cmdStrobe(cmdStrobe), .cmdOp(cmdOp),
		.busy(busy), .bus(bus.seq));

	// address generation and read tags
	scanAddressCounter #(.TableDepth(TableDepth), .ReadLatency(ReadLatency)) cnt_i (
		.CLK(CLK), .RESETn(RESETn), .bus(bus.cnt));

	// entry storage
	freeTableRam #(.TableDepth(TableDepth)) ram_i (
		.CLK(CLK), .bus(bus.ram), .selIn(selIn), .lengthIn(lengthIn));

	// compare rules, found entry and memory sums
	matchAccumulator match_i (.CLK(CLK), .RESETn(RESETn), .cmdStrobe(cmdStrobe), .cmdOp(cmdOp),
		.lengthIn(lengthIn), .bus(bus.match), .found(found), .foundAddr(foundAddr),
		.foundSel(foundSel), .foundLength(foundLength), .cachedMem(cachedMem),
		.freeMem(freeMem));

endmodule

//--- design/freeTableRam.sv
`timescale 1ns/1ps

module freeTableRam #(
	parameter int TableDepth = freeCachePkg::TABLE_DEPTH
) (
	input logic CLK,
	scanIf.ram bus,
	input logic [freeCachePkg::SEL_W-1:0] selIn,
	input logic [freeCachePkg::LEN_W-1:0] lengthIn
);

	localparam int EntryW = freeCachePkg::SEL_W + freeCachePkg::LEN_W;

	// one word per entry, {selector, length}
	logic [EntryW-1:0] mem [TableDepth];

	// --------------------------------------------------
	// single port, write first then registered read
	// --------------------------------------------------
	always_ff @(posedge CLK) begin
		// clear has priority, zero fill
		if (bus.clearing) begin
			mem[bus.ramAddr] <= '0;
		end else if (bus.writeEn) begin
			mem[bus.ramAddr] <= {selIn, lengthIn};
		end
		// read returns the old word on a write cycle
		bus.ramData <= mem[bus.ramAddr];
	end

endmodule

//--- design/matchAccumulator.sv
`timescale 1ns/1ps

module matchAccumulator (
	input logic CLK,
	input logic RESETn,
	input logic cmdStrobe,
	input freeCachePkg::cacheOpT cmdOp,
	input logic [freeCachePkg::LEN_W-1:0] lengthIn,
	scanIf.match bus,
	output logic found,
	output logic [freeCachePkg::ADDR_W-1:0] foundAddr,
	output logic [freeCachePkg::SEL_W-1:0] foundSel,
	output logic [freeCachePkg::LEN_W-1:0] foundLength,
	output logic [freeCachePkg::MEM_W-1:0] cachedMem,
	output logic [freeCachePkg::MEM_W-1:0] freeMem
);

	localparam int LenW = freeCachePkg::LEN_W;
	localparam int EntryW = freeCachePkg::SEL_W + LenW;
	localparam int PadW = freeCachePkg::MEM_W - LenW;
	localparam int AddrW = freeCachePkg::ADDR_W;

	logic [LenW-1:0] reqLength;
	logic [freeCachePkg::SEL_W-1:0] rdSel;
	logic [LenW-1:0] rdLen;
	logic ruleMatch;

	// split the returning table word
	assign rdSel = bus.ramData[EntryW-1:LenW];
	assign rdLen = bus.ramData[LenW-1:0];

	// --------------------------------------------------
	// compare rules
	// --------------------------------------------------
	always_comb begin
		case (bus.op)
			freeCachePkg::opFindFreeObject,
			freeCachePkg::opFindFreeEntry: ruleMatch = (rdSel == '0);
			freeCachePkg::opFindLength: ruleMatch = (rdLen >= reqLength);
			freeCachePkg::opFindUsedEntry: ruleMatch = (rdSel != '0);
			default: ruleMatch = 1'b0;
		endcase
	end

	// first match only, drained reads after it are ignored
	assign bus.hit = bus.rdValid && !found && ruleMatch;

	// requested length held through the scan
	always_ff @(posedge CLK) begin
		if (cmdStrobe && cmdOp == freeCachePkg::opFindLength) reqLength <= lengthIn;
	end

	always_ff @(posedge CLK) begin
		if (!RESETn) found <= 1'b0;
		else if (bus.start) found <= 1'b0;
		else if (bus.hit) found <= 1'b1;
	end

	// captured entry
	always_ff @(posedge CLK) begin
		if (bus.hit) begin
			foundAddr <= AddrW'(bus.rdAddr);
			foundSel <= rdSel;
			foundLength <= rdLen;
		end
	end

	// --------------------------------------------------
	// memory accumulators
	// --------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			cachedMem <= '0;
		end else if (bus.op == freeCachePkg::opCalcCached) begin
			if (bus.start) cachedMem <= '0;
			else if (bus.rdValid) cachedMem <= cachedMem + {{PadW{1'b0}}, rdLen};
		end
	end

	// subtract also removes the header word
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			freeMem <= '0;
		end else if (cmdStrobe) begin
			case (cmdOp)
				freeCachePkg::opMemClear: freeMem <= '0;
				freeCachePkg::opMemAdd: freeMem <= freeMem + {{PadW{1'b0}}, lengthIn};
				freeCachePkg::opMemSub: freeMem <= freeMem - {{PadW{1'b0}}, lengthIn} - 1'b1;
				default: freeMem <= freeMem;
			endcase
		end
	end

endmodule

//--- design/scanAddressCounter.sv
`timescale 1ns/1ps

module scanAddressCounter #(
	parameter int TableDepth = freeCachePkg::TABLE_DEPTH,
	parameter int ReadLatency = 1
) (
	input logic CLK,
	input logic RESETn,
	scanIf.cnt bus
);

	localparam int AddrW = $clog2(TableDepth);

	logic [AddrW-1:0] addrReg;
	logic [AddrW-1:0] firstAddr;
	logic [AddrW-1:0] lastAddr;
	logic [ReadLatency-1:0] tagValid;
	logic [AddrW-1:0] tagAddr [ReadLatency];

	// range per op, object half is the upper half
	always_comb begin
		case (bus.op)
			freeCachePkg::opFindFreeObject,
			freeCachePkg::opFindLength,
			freeCachePkg::opCalcCached: begin
				firstAddr = AddrW'(TableDepth / 2);
				lastAddr = AddrW'(TableDepth - 1);
			end
			freeCachePkg::opFindFreeEntry,
			freeCachePkg::opFindUsedEntry: begin
				firstAddr = '0;
				lastAddr = AddrW'(TableDepth / 2 - 1);
			end
			// clear walks the whole table
			default: begin
				firstAddr = '0;
				lastAddr = AddrW'(TableDepth - 1);
			end
		endcase
	end

	assign bus.rangeEnd = bus.scanning && (addrReg == lastAddr);
	assign bus.ramAddr = addrReg;

	// --------------------------------------------------
	// scan address register
	// --------------------------------------------------
	// hit rewinds to the matching entry, range end holds the last address
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			addrReg <= '0;
		end else if (bus.start) begin
			addrReg <= firstAddr;
		end else if (bus.hit) begin
			addrReg <= bus.rdAddr;
		end else if (bus.scanning && !bus.rangeEnd) begin
			addrReg <= addrReg + 1'b1;
		end
	end

	// read tags, aligned with table read data
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			tagValid <= '0;
		end else begin
			tagValid[0] <= bus.scanning;
			for (int i = 1; i < ReadLatency; i++) tagValid[i] <= tagValid[i-1];
		end
	end

	always_ff @(posedge CLK) begin
		tagAddr[0] <= addrReg;
		for (int i = 1; i < ReadLatency; i++) tagAddr[i] <= tagAddr[i-1];
	end

	assign bus.rdValid = tagValid[ReadLatency-1];
	assign bus.rdAddr = tagAddr[ReadLatency-1];

endmodule

//--- design/scanIf.sv
`timescale 1ns/1ps

interface scanIf #(
	// smallest supported depth
	parameter int TableDepth = 4,
	parameter type opT = logic,
	parameter type entryT = logic
);

	localparam int AddrW = $clog2(TableDepth);

	// from the sequencer
	opT op;
	logic start;
	logic scanning;
	logic writeEn;
	logic clearing;
	// from the address counter
	logic [AddrW-1:0] ramAddr;
	logic rdValid;
	logic [AddrW-1:0] rdAddr;
	logic rangeEnd;
	// from the table and the match unit
	entryT ramData;
	logic hit;

	modport seq (output op, start, scanning, writeEn, clearing, input hit, rangeEnd, rdValid);
	modport cnt (input op, start, scanning, hit, output ramAddr, rdValid, rdAddr, rangeEnd);
	modport ram (input ramAddr, writeEn, clearing, output ramData);
	modport match (input op, start, rdValid, rdAddr, ramData, output hit);

endinterface

//--- design/scanSequencer.sv
`timescale 1ns/1ps

module scanSequencer (
	input logic CLK,
	input logic RESETn,
	input logic cmdStrobe,
	input freeCachePkg::cacheOpT cmdOp,
	output logic busy,
	scanIf.seq bus
);

	freeCachePkg::seqStateT state;
	freeCachePkg::cacheOpT opReg;
	logic startReg;
	logic tableCmd;

	// commands that touch the table
	// mem ops bypass the sequencer
	always_comb begin
		case (cmdOp)
			freeCachePkg::opWrite,
			freeCachePkg::opClear,
			freeCachePkg::opFindFreeObject,
			freeCachePkg::opFindFreeEntry,
			freeCachePkg::opFindLength,
			freeCachePkg::opFindUsedEntry,
			freeCachePkg::opCalcCached: tableCmd = 1'b1;
			default: tableCmd = 1'b0;
		endcase
	end

	// --------------------------------------------------
	// state machine
	// --------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			state <= freeCachePkg::stIdle;
			opReg <= freeCachePkg::opNone;
			startReg <= 1'b0;
		end else begin
			startReg <= 1'b0;
			case (state)
				freeCachePkg::stIdle: begin
					if (cmdStrobe && tableCmd) begin
						opReg <= cmdOp;
						if (cmdOp == freeCachePkg::opWrite) begin
							state <= freeCachePkg::stWrite;
						end else begin
							state <= freeCachePkg::stScan;
							startReg <= 1'b1;
						end
					end
				end
				// single write cycle
				freeCachePkg::stWrite: state <= freeCachePkg::stIdle;
				// stop issuing on first hit or last address
				freeCachePkg::stScan: if (bus.hit || bus.rangeEnd) state <= freeCachePkg::stDrain;
				// wait for the read pipeline to empty
				freeCachePkg::stDrain: if (!bus.rdValid) state <= freeCachePkg::stIdle;
				default: state <= freeCachePkg::stIdle;
			endcase
		end
	end

	assign busy = (state != freeCachePkg::stIdle);
	assign bus.op = opReg;
	assign bus.start = startReg;
	// counter loads during the start cycle, issue begins after it
	assign bus.scanning = (state == freeCachePkg::stScan) && !startReg;
	assign bus.writeEn = (state == freeCachePkg::stWrite);
	assign bus.clearing = bus.scanning && (opReg == freeCachePkg::opClear);

endmodule

//--- freeObjectCache.f
design/freeCachePkg.sv
design/scanIf.sv
design/scanSequencer.sv
design/scanAddressCounter.sv
design/freeTableRam.sv
design/matchAccumulator.sv
design/freeObjectCache.sv
verif/freeObjectCache_assert.sv
verif/freeObjectCacheTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run, the exit status is the test result
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal --top-module freeObjectCacheTb \
		-f freeObjectCache.f -o freeObjectCacheSim \
	&& ./obj_dir/freeObjectCacheSim \
	|| exit 1

//--- verif/freeObjectCacheTb.sv
`timescale 1ns/1ps

module freeObjectCacheTb;

	localparam int ClkPeriod = 4;
	localparam int Depth = freeCachePkg::TABLE_DEPTH;
	localparam int Half = Depth / 2;
	localparam int SelW = freeCachePkg::SEL_W;
	localparam int LenW = freeCachePkg::LEN_W;
	localparam int MemW = freeCachePkg::MEM_W;

	// one command row
	typedef struct {
		freeCachePkg::cacheOpT op;
		logic [SelW-1:0] sel;
		logic [LenW-1:0] len;
	} rowT;

	logic CLK;
	logic RESETn;
	logic cmdStrobe;
	freeCachePkg::cacheOpT cmdOp;
	logic [SelW-1:0] selIn;
	logic [LenW-1:0] lengthIn;
	logic busy;
	logic found;
	logic [freeCachePkg::ADDR_W-1:0] foundAddr;
	logic [SelW-1:0] foundSel;
	logic [LenW-1:0] foundLength;
	logic [MemW-1:0] cachedMem;
	logic [MemW-1:0] freeMem;

	// command table
	rowT rows [$];
	bit tableReady;
	// reference model of table, scan register and accumulators
	logic [SelW-1:0] modelSel [Depth];
	logic [LenW-1:0] modelLen [Depth];
	int modelAddr;
	logic [MemW-1:0] modelFree;
	logic [MemW-1:0] modelCached;
	bit expFound;
	int expAddr;

	freeObjectCache dut_i (
		.CLK(CLK), .RESETn(RESETn), .cmdStrobe(cmdStrobe), .cmdOp(cmdOp), .selIn(selIn),
		.lengthIn(lengthIn), .busy(busy), .found(found), .foundAddr(foundAddr),
		.foundSel(foundSel), .foundLength(foundLength), .cachedMem(cachedMem),
		.freeMem(freeMem));

	// sequencer checks
	bind scanSequencer freeObjectCacheAssert assert_i (
		.CLK(CLK), .RESETn(RESETn), .busy(busy), .state(state), .hit(bus.hit));

	initial begin
		CLK = 1'b0;
		forever #(ClkPeriod / 2) CLK = ~CLK;
	end

	task automatic stopWithFailure();
		$display("Finished with errors");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			$display("ERROR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
			stopWithFailure();
		end
	endtask

	// never zero so a written entry counts as used
	function automatic logic [SelW-1:0] randomSel();
		return SelW'($urandom) | SelW'(1);
	endfunction

	// top bit clear so an all ones request finds nothing
	function automatic logic [LenW-1:0] randomLen();
		return $urandom & 32'h7fff_ffff;
	endfunction

	task automatic addRow(input freeCachePkg::cacheOpT op, input logic [SelW-1:0] sel,
		input logic [LenW-1:0] len);
		rows.push_back('{op, sel, len});
	endtask

	// --------------------------------------------------
	// command table
	// --------------------------------------------------
	task automatic buildTable();
		logic [LenW-1:0] lens [8];
		addRow(freeCachePkg::opMemClear, '0, '0);
		addRow(freeCachePkg::opClear, '0, '0);
		// empty table
		addRow(freeCachePkg::opFindUsedEntry, '0, '0);
		addRow(freeCachePkg::opCalcCached, '0, '0);
		// fill object half in order
		for (int i = 0; i < 8; i++) begin
			lens[i] = randomLen();
			addRow(freeCachePkg::opFindFreeObject, '0, '0);
			addRow(freeCachePkg::opWrite, randomSel(), lens[i]);
		end
		addRow(freeCachePkg::opFindFreeObject, '0, '0);
		addRow(freeCachePkg::opFindLength, '0, lens[5]);
		addRow(freeCachePkg::opFindLength, '0, 32'h4000_0000);
		addRow(freeCachePkg::opFindLength, '0, '1);
		// scattered entry half writes
		addRow(freeCachePkg::opFindUsedEntry, '0, '0);
		addRow(freeCachePkg::opWrite, randomSel(), randomLen());
		addRow(freeCachePkg::opFindFreeEntry, '0, '0);
		addRow(freeCachePkg::opWrite, randomSel(), randomLen());
		addRow(freeCachePkg::opFindFreeEntry, '0, '0);
		addRow(freeCachePkg::opWrite, randomSel(), randomLen());
		// free the first used entry again
		addRow(freeCachePkg::opFindUsedEntry, '0, '0);
		addRow(freeCachePkg::opWrite, '0, randomLen());
		addRow(freeCachePkg::opFindFreeEntry, '0, '0);
		addRow(freeCachePkg::opFindUsedEntry, '0, '0);
		addRow(freeCachePkg::opCalcCached, '0, '0);
		// free memory counter where the last sub wraps below zero
		addRow(freeCachePkg::opMemAdd, '0, randomLen());
		addRow(freeCachePkg::opMemAdd, '0, randomLen());
		addRow(freeCachePkg::opMemSub, '0, 32'h0000_1000);
		addRow(freeCachePkg::opMemClear, '0, '0);
		addRow(freeCachePkg::opMemSub, '0, 32'd5);
		addRow(freeCachePkg::opMemAdd, '0, randomLen());
	endtask

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	task automatic applyModel(input rowT r);
		int first;
		bit match;
		case (r.op)
			freeCachePkg::opWrite: begin
				modelSel[modelAddr] = r.sel;
				modelLen[modelAddr] = r.len;
			end
			freeCachePkg::opClear: begin
				expFound = 1'b0;
				foreach (modelSel[a]) modelSel[a] = '0;
				foreach (modelLen[a]) modelLen[a] = '0;
				modelAddr = Depth - 1;
			end
			freeCachePkg::opCalcCached: begin
				expFound = 1'b0;
				modelCached = '0;
				for (int a = Half; a < Depth; a++) modelCached = modelCached + MemW'(modelLen[a]);
				modelAddr = Depth - 1;
			end
			freeCachePkg::opMemClear: modelFree = '0;
			freeCachePkg::opMemAdd: modelFree = modelFree + MemW'(r.len);
			freeCachePkg::opMemSub: modelFree = modelFree - MemW'(r.len) - MemW'(1);
			default: begin
				// first match wins in the four find scans
				expFound = 1'b0;
				first = (r.op == freeCachePkg::opFindFreeObject ||
					r.op == freeCachePkg::opFindLength) ? Half : 0;
				modelAddr = first + Half - 1;
				for (int a = first; a < first + Half && !expFound; a++) begin
					case (r.op)
						freeCachePkg::opFindFreeObject,
						freeCachePkg::opFindFreeEntry: match = (modelSel[a] == '0);
						freeCachePkg::opFindLength: match = (modelLen[a] >= r.len);
						default: match = (modelSel[a] != '0);
					endcase
					if (match) begin
						expFound = 1'b1;
						expAddr = a;
						modelAddr = a;
					end
				end
			end
		endcase
	endtask

	// counts the cycles busy stays high after the first check
	task automatic waitIdle(output int cycles);
		cycles = 0;
		while (busy) begin
			@(negedge CLK);
			cycles++;
			assert (cycles < 300) else begin
				$display("busy stayed high for 300 cycles, the scan never ended");
				stopWithFailure();
			end
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		rowT r;
		bit isMem;
		bit isScan;
		int busyLen;
		RESETn = 1'b0;
		cmdStrobe = 1'b0;
		cmdOp = freeCachePkg::opNone;
		selIn = '0;
		lengthIn = '0;
		tableReady = 1'b0;
		modelAddr = 0;
		modelFree = '0;
		modelCached = '0;
		expFound = 1'b0;
		expAddr = 0;
		void'($urandom(32'hbac3));
		buildTable();
		tableReady = 1'b1;
		repeat (5) @(posedge CLK);
		RESETn <= 1'b1;
		foreach (rows[i]) begin
			r = rows[i];
			isMem = r.op inside {freeCachePkg::opMemClear, freeCachePkg::opMemAdd,
				freeCachePkg::opMemSub};
			isScan = !isMem && (r.op != freeCachePkg::opWrite);
			applyModel(r);
			@(posedge CLK);
			cmdStrobe <= 1'b1;
			cmdOp <= r.op;
			selIn <= r.sel;
			lengthIn <= r.len;
			@(posedge CLK);
			cmdStrobe <= 1'b0;
			@(negedge CLK);
			// table commands raise busy while mem ops are already done
			checkValue("busy", 64'(busy), 64'(!isMem));
			waitIdle(busyLen);
			// a write holds busy for exactly one cycle
			if (r.op == freeCachePkg::opWrite) begin
				checkValue("write busy length", 64'(busyLen), 64'd1);
			end
			checkValue("freeMem", 64'(freeMem), 64'(modelFree));
			if (isScan) begin
				checkValue("found", 64'(found), 64'(expFound));
			end
			if (isScan && expFound) begin
				checkValue("foundAddr", 64'(foundAddr), 64'(expAddr));
				checkValue("foundSel", 64'(foundSel), 64'(modelSel[expAddr]));
				checkValue("foundLength", 64'(foundLength), 64'(modelLen[expAddr]));
			end
			if (r.op == freeCachePkg::opCalcCached) begin
				checkValue("cachedMem", 64'(cachedMem), 64'(modelCached));
			end
		end
		$display("Finished with no errors");
		$finish;
	end

	// watchdog sized from the row count since a clear takes about 260 cycles
	initial begin
		wait (tableReady);
		repeat (rows.size() * 300) @(posedge CLK);
		$display("watchdog expired before the command table finished");
		stopWithFailure();
	end

endmodule

//--- verif/freeObjectCache_assert.sv
`timescale 1ns/1ps

module freeObjectCacheAssert (
	input logic CLK,
	input logic RESETn,
	input logic busy,
	input freeCachePkg::seqStateT state,
	input logic hit
);

	// clear walks the whole table plus the drain
	localparam int MaxBusy = 270;

	int busyCycles;

	// length of the current busy period
	always_ff @(posedge CLK) begin
		if (!RESETn) busyCycles <= 0;
		else if (busy) busyCycles <= busyCycles + 1;
		else busyCycles <= 0;
	end

	// idle out of reset
	assert property (@(posedge CLK) !RESETn |=> !busy)
		else $error("busy high after reset");

	// hits only from a running or draining scan
	assert property (@(posedge CLK) disable iff (!RESETn)
		hit |-> (state == freeCachePkg::stScan || state == freeCachePkg::stDrain))
		else $error("hit outside a scan");

	assert property (@(posedge CLK) disable iff (!RESETn) busyCycles <= MaxBusy)
		else $error("busy did not fall within %0d cycles", MaxBusy);

endmodule
